/* logic/mipsAlu.sv */
`timescale 1ns/1ps

module mipsAlu
   import mipsIsaPkg::*, mipsCtrlPkg::*;
(
   input  aluOpT op,
   input  wordT  a,
   input  wordT  b,
   output wordT  result,
   output logic  zero
);

   logic        subtract;
   wordT        bOperand;
   logic [32:0] sum;
   logic        overflow;
   logic        lessSigned;
   logic        lessUnsigned;

   assign subtract = (op == aluSub) || (op == aluSubu) || (op == aluSlt) || (op == aluSltu);

   // Single adder, b inverted plus carry-in for subtraction
   assign bOperand = subtract ? ~b : b;
   assign sum      = {1'b0, a} + {1'b0, bOperand} + 33'(subtract);

   // Overflow of a - b
   assign overflow     = (a[31] != b[31]) && (a[31] != sum[31]);
   assign lessSigned   = sum[31] ^ overflow;
   assign lessUnsigned = ~sum[32]; // Borrow out

   always_comb
   begin
      case (op)
         aluAdd, aluAddu, aluSub, aluSubu: result = sum[31:0];
         aluSlt:  result = wordT'(lessSigned);
         aluSltu: result = wordT'(lessUnsigned);
         aluAnd:  result = a & b;
         aluOr:   result = a | b;
         aluXor:  result = a ^ b;
         aluNor:  result = ~(a | b);
         default: result = '0;
      endcase
   end

   assign zero = (result == '0);

endmodule

/* logic/mipsController.sv */
`timescale 1ns/1ps

module mipsController
   import mipsIsaPkg::*, mipsCtrlPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  opcodeT     opcode,
   input  functT      funct,
   input  logic       aluZero,
   output logic       pcWrite,
   output logic       irWrite,
   output logic       mdrWrite,
   output logic       marWrite,
   output logic       aWrite,
   output logic       bWrite,
   output logic       regWrite,
   output logic       setRead,
   output logic       clrRead,
   output logic       setWrite,
   output logic       clrWrite,
   output aluOpT      aluOp,
   output aluSrcAT    aluSrcA,
   output aluSrcBT    aluSrcB,
   output logic       signExt,
   output regDstT     regDst,
   output wbSrcT      wbSrc,
   output pcSrcT      pcSrc,
   output memAddrSrcT memAddrSrc
);

   ctrlStateT state, nextState;
   aluOpT     rOp, iOp;
   logic      rValid;
   logic      iSignExt;
   logic      prepFetch;

   // ==============================
   // Instruction decode
   always_comb
   begin
      rOp    = aluAdd;
      rValid = 1'b1;
      case (funct)
         fnAdd:   rOp = aluAdd;
         fnAddu:  rOp = aluAddu;
         fnSub:   rOp = aluSub;
         fnSubu:  rOp = aluSubu;
         fnAnd:   rOp = aluAnd;
         fnOr:    rOp = aluOr;
         fnXor:   rOp = aluXor;
         fnNor:   rOp = aluNor;
         fnSlt:   rOp = aluSlt;
         fnSltu:  rOp = aluSltu;
         default: rValid = 1'b0;
      endcase
   end

   always_comb
   begin
      iOp      = aluAdd; // addi, lw, sw
      iSignExt = 1'b1;
      case (opcode)
         opAddiu: iOp = aluAddu;
         opSlti:  iOp = aluSlt;
         opSltiu: iOp = aluSltu;
         opAndi:  iOp = aluAnd;
         opOri:   iOp = aluOr;
         opXori:  iOp = aluXor;
         default: iOp = aluAdd;
      endcase
      if (opcode == opAndi || opcode == opOri || opcode == opXori)
         iSignExt = 1'b0; // Logic immediates zero-extend
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= stReset;
      else
         state <= nextState;
   end

   // ==============================
   // State machine
   always_comb
   begin
      nextState  = state;
      prepFetch  = 1'b0;
      {pcWrite, irWrite, mdrWrite, marWrite, aWrite, bWrite, regWrite} = '0;
      {setRead, clrRead, setWrite, clrWrite} = '0;
      aluOp      = aluAdd;
      aluSrcA    = srcAPc;
      aluSrcB    = srcBRegB;
      signExt    = 1'b1;
      regDst     = regDstRt;
      wbSrc      = wbAlu;
      pcSrc      = pcSrcAlu;
      memAddrSrc = memAddrPc;

      case (state)
         stReset:  prepFetch = 1'b1;
         stFetch1: nextState = stFetch2;
         stFetch2: nextState = stFetch3;
         stFetch3:
         begin
            irWrite   = 1'b1;
            clrRead   = 1'b1;
            pcWrite   = 1'b1;     // PC + 4
            aluSrcB   = srcBFour;
            nextState = stDecode;
         end
         stDecode:
         begin
            aWrite = 1'b1;
            bWrite = 1'b1;
            case (opcode)
               opRType:
               begin
                  if (rValid)
                     nextState = stExAluR;
                  else
                     prepFetch = 1'b1;
               end
               opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori:
                  nextState = stExAluI;
               opLw:         nextState = stLw1;
               opSw:         nextState = stSw1;
               opBeq, opBne: nextState = stBranch1;
               opJ:          nextState = stJump;
               opLui:        nextState = stLui;
               default:      prepFetch = 1'b1; // Unknown opcode, no-op
            endcase
         end
         stExAluR:
         begin
            aluSrcA   = srcARegA;
            aluOp     = rOp;
            regDst    = regDstRd;
            regWrite  = 1'b1;
            prepFetch = 1'b1;
         end
         stExAluI:
         begin
            aluSrcA   = srcARegA;
            aluSrcB   = srcBImm;
            aluOp     = iOp;
            signExt   = iSignExt;
            regWrite  = 1'b1;
            prepFetch = 1'b1;
         end
         stLw1, stSw1:
         begin
            aluSrcA    = srcARegA;
            aluSrcB    = srcBImm;
            memAddrSrc = memAddrAlu;
            marWrite   = 1'b1;
            setRead    = (state == stLw1);
            nextState  = (state == stLw1) ? stLw2 : stSw2;
         end
         stLw2: nextState = stLw3;
         stLw3: nextState = stLw4;
         stLw4:
         begin
            mdrWrite  = 1'b1;
            clrRead   = 1'b1;
            nextState = stLw5;
         end
         stLw5:
         begin
            wbSrc     = wbMdr;
            regWrite  = 1'b1;
            prepFetch = 1'b1;
         end
         stSw2:
         begin
            setWrite  = 1'b1;
            nextState = stSw3;
         end
         stSw3:
         begin
            clrWrite  = 1'b1;
            prepFetch = 1'b1;
         end
         stBranch1:
         begin
            aluSrcA = srcARegA;
            aluOp   = aluSub;
            if (aluZero ^ opcode[0]) // opcode bit 0 marks bne
               nextState = stBranch2;
            else
               prepFetch = 1'b1;
         end
         stBranch2:
         begin
            aluSrcB   = srcBImmShifted; // PC + 4 + offset
            pcWrite   = 1'b1;
            prepFetch = 1'b1;
         end
         stJump:
         begin
            pcSrc     = pcSrcJump;
            pcWrite   = 1'b1;
            prepFetch = 1'b1;
         end
         stLui:
         begin
            wbSrc     = wbUpperImm;
            regWrite  = 1'b1;
            prepFetch = 1'b1;
         end
         default: nextState = stReset;
      endcase

      // Shared next-fetch action
      if (prepFetch)
      begin
         memAddrSrc = memAddrPc;
         setRead    = 1'b1;
         marWrite   = 1'b1;
         nextState  = stFetch1;
      end
   end

endmodule

/* logic/mipsCtrlPkg.sv */
package mipsCtrlPkg;

   typedef enum logic [3:0] {
      aluAdd  = 4'b0000,
      aluSub  = 4'b0001,
      aluSlt  = 4'b0010,
      aluSltu = 4'b0011,
      aluAnd  = 4'b0100,
      aluXor  = 4'b0101,
      aluOr   = 4'b0110,
      aluNor  = 4'b0111,
      aluAddu = 4'b1000,
      aluSubu = 4'b1001
   } aluOpT;

   typedef enum logic [4:0] {
      stReset, stFetch1, stFetch2, stFetch3, stDecode,
      stExAluR, stExAluI,
      stLw1, stLw2, stLw3, stLw4, stLw5,
      stSw1, stSw2, stSw3,
      stBranch1, stBranch2, stJump, stLui
   } ctrlStateT;

   // Datapath mux selects
   typedef enum logic       {srcAPc, srcARegA} aluSrcAT;
   typedef enum logic [1:0] {srcBRegB, srcBFour, srcBImm, srcBImmShifted} aluSrcBT;
   typedef enum logic       {regDstRt, regDstRd} regDstT;
   typedef enum logic [1:0] {wbAlu, wbMdr, wbUpperImm} wbSrcT;
   typedef enum logic       {pcSrcAlu, pcSrcJump} pcSrcT;
   typedef enum logic       {memAddrPc, memAddrAlu} memAddrSrcT;

endpackage

/* logic/mipsDatapath.sv */
`timescale 1ns/1ps

module mipsDatapath
   import mipsIsaPkg::*, mipsCtrlPkg::*;
#(
   parameter wordT ResetAddr = '0
)
(
   input  logic       clk,
   input  logic       reset,
   input  logic       pcWrite,
   input  logic       irWrite,
   input  logic       mdrWrite,
   input  logic       marWrite,
   input  logic       aWrite,
   input  logic       bWrite,
   input  logic       regWrite,
   input  logic       setRead,
   input  logic       clrRead,
   input  logic       setWrite,
   input  logic       clrWrite,
   input  aluOpT      aluOp,
   input  aluSrcAT    aluSrcA,
   input  aluSrcBT    aluSrcB,
   input  logic       signExt,
   input  regDstT     regDst,
   input  wbSrcT      wbSrc,
   input  pcSrcT      pcSrc,
   input  memAddrSrcT memAddrSrc,
   output opcodeT     opcode,
   output functT      funct,
   output logic       aluZero,
   output wordT       memAddr,
   output wordT       memWriteData,
   output logic       memRead,
   output logic       memWrite,
   input  wordT       memReadData
);

   wordT    pc, ir, mdr, mar, aReg, bReg;
   wordT    rfData1, rfData2;
   wordT    aluA, aluB, aluResult;
   wordT    extImm, jumpTarget, pcMux, pcNext, wbData;
   immT     imm;
   regAddrT wbAddr;

   assign opcode     = ir[31:26];
   assign funct      = ir[5:0];
   assign imm        = ir[15:0];
   assign extImm     = signExt ? {{16{imm[15]}}, imm} : {16'h0000, imm};
   assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};

   // ==============================
   // PC and MAR sources
   assign pcMux  = (pcSrc == pcSrcJump) ? jumpTarget : aluResult;
   assign pcNext = pcWrite ? pcMux : pc; // MAR follows the PC being loaded

   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= ResetAddr;
      else if (pcWrite)
         pc <= pcMux;
   end

   always_ff @(posedge clk)
   begin
      if (marWrite)
         mar <= (memAddrSrc == memAddrAlu) ? aluResult : pcNext;
      if (irWrite)
         ir <= memReadData;
      if (mdrWrite)
         mdr <= memReadData;
      if (aWrite)
         aReg <= rfData1;
      if (bWrite)
         bReg <= rfData2;
   end

   // Memory strobes, clear wins over set
   always_ff @(posedge clk)
   begin
      if (reset || clrRead)
         memRead <= 1'b0;
      else if (setRead)
         memRead <= 1'b1;
      if (reset || clrWrite)
         memWrite <= 1'b0;
      else if (setWrite)
         memWrite <= 1'b1;
   end

   assign memAddr      = mar;
   assign memWriteData = bReg;

   // ==============================
   // Operand and write-back muxes
   assign aluA = (aluSrcA == srcARegA) ? aReg : pc;

   always_comb
   begin
      case (aluSrcB)
         srcBRegB:       aluB = bReg;
         srcBFour:       aluB = 32'd4;
         srcBImm:        aluB = extImm;
         srcBImmShifted: aluB = {extImm[29:0], 2'b00};
         default:        aluB = bReg;
      endcase
   end

   always_comb
   begin
      case (wbSrc)
         wbMdr:      wbData = mdr;
         wbUpperImm: wbData = {imm, 16'h0000};
         default:    wbData = aluResult;
      endcase
   end

   assign wbAddr = (regDst == regDstRd) ? ir[15:11] : ir[20:16];

   mipsRegFile mipsRegFile_inst (
      .clk         (clk),
      .readAddr1   (ir[25:21]),
      .readAddr2   (ir[20:16]),
      .readData1   (rfData1),
      .readData2   (rfData2),
      .writeEnable (regWrite),
      .writeAddr   (wbAddr),
      .writeData   (wbData)
   );

   mipsAlu mipsAlu_inst (
      .op     (aluOp),
      .a      (aluA),
      .b      (aluB),
      .result (aluResult),
      .zero   (aluZero)
   );

endmodule

/* logic/mipsIsaPkg.sv */
package mipsIsaPkg;

   typedef logic [31:0] wordT;
   typedef logic [4:0]  regAddrT;
   typedef logic [5:0]  opcodeT;
   typedef logic [5:0]  functT;
   typedef logic [15:0] immT;

   // Primary opcodes
   localparam opcodeT opRType = 6'b000000;
   localparam opcodeT opJ     = 6'b000010;
   localparam opcodeT opBeq   = 6'b000100;
   localparam opcodeT opBne   = 6'b000101;
   localparam opcodeT opAddi  = 6'b001000;
   localparam opcodeT opAddiu = 6'b001001;
   localparam opcodeT opSlti  = 6'b001010;
   localparam opcodeT opSltiu = 6'b001011;
   localparam opcodeT opAndi  = 6'b001100;
   localparam opcodeT opOri   = 6'b001101;
   localparam opcodeT opXori  = 6'b001110;
   localparam opcodeT opLui   = 6'b001111;
   localparam opcodeT opLw    = 6'b100011;
   localparam opcodeT opSw    = 6'b101011;

   // R-format function codes
   localparam functT fnAdd  = 6'b100000;
   localparam functT fnAddu = 6'b100001;
   localparam functT fnSub  = 6'b100010;
   localparam functT fnSubu = 6'b100011;
   localparam functT fnAnd  = 6'b100100;
   localparam functT fnOr   = 6'b100101;
   localparam functT fnXor  = 6'b100110;
   localparam functT fnNor  = 6'b100111;
   localparam functT fnSlt  = 6'b101010;
   localparam functT fnSltu = 6'b101011;

endpackage

/* logic/mipsMultiCycle.sv */
`timescale 1ns/1ps

module mipsMultiCycle
   import mipsIsaPkg::*, mipsCtrlPkg::*;
#(
   parameter wordT ResetAddr = '0
)
(
   input  logic clk,
   input  logic reset,
   output wordT memAddr,
   output wordT memWriteData,
   output logic memRead,
   output logic memWrite,
   input  wordT memReadData
);

   // Controller to datapath
   logic       pcWrite, irWrite, mdrWrite, marWrite;
   logic       aWrite, bWrite, regWrite;
   logic       setRead, clrRead, setWrite, clrWrite;
   aluOpT      aluOp;
   aluSrcAT    aluSrcA;
   aluSrcBT    aluSrcB;
   logic       signExt;
   regDstT     regDst;
   wbSrcT      wbSrc;
   pcSrcT      pcSrc;
   memAddrSrcT memAddrSrc;

   // Datapath to controller
   opcodeT     opcode;
   functT      funct;
   logic       aluZero;

   mipsDatapath #(
      .ResetAddr (ResetAddr)
   ) mipsDatapath_inst (.*);

   mipsController mipsController_inst (.*);

endmodule

/* logic/mipsRegFile.sv */
`timescale 1ns/1ps

module mipsRegFile
   import mipsIsaPkg::*;
(
   input  logic    clk,
   input  regAddrT readAddr1,
   input  regAddrT readAddr2,
   output wordT    readData1,
   output wordT    readData2,
   input  logic    writeEnable,
   input  regAddrT writeAddr,
   input  wordT    writeData
);

   wordT regs [32];

   // Register 0 is hardwired
   assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
   assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

   always_ff @(posedge clk)
   begin
      if (writeEnable && (writeAddr != '0))
      begin
         regs[writeAddr] <= writeData;
      end
   end

endmodule

/* mipsMultiCycle.f */
logic/mipsIsaPkg.sv
logic/mipsCtrlPkg.sv
logic/mipsAlu.sv
logic/mipsRegFile.sv
logic/mipsDatapath.sv
logic/mipsController.sv
logic/mipsMultiCycle.sv
tests/mipsMultiCycle_chk.sv
tests/mipsMultiCycleTb.sv

/* run.sh */
#!/bin/sh
# Build and run the mipsMultiCycle testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module mipsMultiCycleTb -f mipsMultiCycle.f -o simv
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/simv 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "Done: no errors"; then
   exit 0
fi
exit 1

/* tests/mipsMultiCycleTb.sv */
`timescale 1ns/1ps

module mipsMultiCycleTb
   import mipsIsaPkg::*;
;

   localparam int CycleLimit = 600; // Whole run, 6 tests x about 12 instr x 8 cycles

   logic     clk;
   logic     reset;
   wordT     memAddr;
   wordT     memWriteData;
   logic     memRead;
   logic     memWrite;
   wordT     memReadData;

   wordT     mem [256];
   logic [7:0] progLen;
   int       cycles;
   int       seed;
   string    testName;

   mipsMultiCycle mipsMultiCycle_inst (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ==============================
   // Memory model, one cycle read latency
   always @(posedge clk)
   begin
      if (memWrite)
         mem[memAddr[9:2]] <= memWriteData;
      if (memRead)
         memReadData <= mem[memAddr[9:2]];
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= CycleLimit)
      begin
         $display("Timeout: %0d cycles passed and test %s still waits for a store",
                  CycleLimit, testName);
         $display("Done: errors found");
         $fatal(1, "simulation stopped on timeout");
      end
   end

   // ==============================
   // Instruction encoding
   function automatic wordT rType(functT fn, regAddrT rs, regAddrT rt, regAddrT rd);
      return {opRType, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic wordT iType(opcodeT op, regAddrT rs, regAddrT rt, immT imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic wordT jType(logic [25:0] index);
      return {opJ, index};
   endfunction

   // Reference arithmetic
   function automatic wordT aluExpect(functT fn, wordT a, wordT b);
      case (fn)
         fnAdd, fnAddu: return a + b;
         fnSub, fnSubu: return a - b;
         fnAnd:         return a & b;
         fnOr:          return a | b;
         fnXor:         return a ^ b;
         fnNor:         return ~(a | b);
         fnSlt:         return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         default:       return (a < b) ? 32'd1 : 32'd0;
      endcase
   endfunction

   function automatic wordT immExpect(opcodeT op, wordT a, immT imm);
      wordT sx;
      wordT zx;
      sx = {{16{imm[15]}}, imm};
      zx = {16'h0000, imm};
      case (op)
         opAddi, opAddiu: return a + sx;
         opSlti:          return ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
         opSltiu:         return (a < sx) ? 32'd1 : 32'd0;
         opAndi:          return a & zx;
         opOri:           return a | zx;
         default:         return a ^ zx;
      endcase
   endfunction

   // ==============================
   // Program loading and store checks
   task automatic startTest(string name);
      @(posedge clk);
      reset <= 1'b1;
      testName = name;
      progLen  = 8'd0;
      for (int i = 0; i < 256; i++)
         mem[8'(i)] <= 32'ha5a5_0000 ^ (i * 4); // Fill tied to byte address
   endtask

   task automatic emit(wordT instr);
      mem[progLen] <= instr;
      progLen = progLen + 8'd1;
   endtask

   task automatic runProgram();
      emit(jType(26'(progLen))); // Park in a jump-to-self
      repeat (5) @(posedge clk);
      reset <= 1'b0;
   endtask

   task automatic checkWord(wordT expected, wordT actual);
      if (expected !== actual)
      begin
         $display("ERR %s store data: expected %h, actual %h", testName, expected, actual);
         $display("Done: errors found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic checkAddr(wordT expected, wordT actual);
      if (expected !== actual)
      begin
         $display("ERR %s store address: expected %h, actual %h", testName, expected, actual);
         $display("Done: errors found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic expectStore(wordT addr, wordT data);
      do
         @(negedge clk);
      while (!memWrite);
      checkAddr(addr, memAddr);
      checkWord(data, memWriteData);
   endtask

   // ==============================
   // Directed tests
   task automatic aluRegTest();
      functT fns [10];
      wordT  a;
      wordT  b;
      fns = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};
      a = $random(seed);
      b = $random(seed);
      a[31] = 1'b1; // Opposite signs so slt and sltu differ
      b[31] = 1'b0;
      startTest("aluRegTest");
      mem[8'd192] <= a;
      mem[8'd193] <= b;
      emit(iType(opLw, 5'd0, 5'd1, 16'h0300));
      emit(iType(opLw, 5'd0, 5'd2, 16'h0304));
      for (int k = 0; k < 10; k++)
      begin
         emit(rType(fns[k], 5'd1, 5'd2, 5'd3));
         emit(iType(opSw, 5'd0, 5'd3, immT'(16'h0380 + 4 * k)));
      end
      runProgram();
      for (int k = 0; k < 10; k++)
         expectStore(32'h380 + 4 * k, aluExpect(fns[k], a, b));
   endtask

   task automatic aluImmTest();
      opcodeT ops [7];
      immT    imms [7];
      wordT   a;
      ops = '{opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori};
      a = $random(seed);
      for (int k = 0; k < 7; k++)
         imms[k] = immT'($random(seed)) | 16'h8000; // Top bit set, sign and zero ext differ
      startTest("aluImmTest");
      mem[8'd192] <= a;
      emit(iType(opLw, 5'd0, 5'd1, 16'h0300));
      for (int k = 0; k < 7; k++)
      begin
         emit(iType(ops[k], 5'd1, 5'd3, imms[k]));
         emit(iType(opSw, 5'd0, 5'd3, immT'(16'h0380 + 4 * k)));
      end
      runProgram();
      for (int k = 0; k < 7; k++)
         expectStore(32'h380 + 4 * k, immExpect(ops[k], a, imms[k]));
   endtask

   task automatic loadStoreTest();
      wordT w1;
      wordT w2;
      w1 = $random(seed);
      w2 = $random(seed);
      startTest("loadStoreTest");
      mem[8'd193] <= w1;
      mem[8'd194] <= w2;
      emit(iType(opAddi, 5'd0, 5'd1, 16'h0340)); // Base register
      emit(iType(opLw, 5'd0, 5'd2, 16'h0304));
      emit(iType(opLw, 5'd0, 5'd5, 16'h0308));
      emit(iType(opSw, 5'd1, 5'd2, 16'h0008));
      emit(iType(opSw, 5'd1, 5'd5, 16'hfffc)); // Negative offset
      emit(iType(opLw, 5'd1, 5'd3, 16'h0008));
      emit(iType(opLw, 5'd1, 5'd4, 16'hfffc));
      emit(iType(opSw, 5'd1, 5'd3, 16'h0020));
      emit(iType(opSw, 5'd1, 5'd4, 16'h0024));
      runProgram();
      expectStore(32'h348, w1);
      expectStore(32'h33c, w2);
      expectStore(32'h360, w1);
      expectStore(32'h364, w2);
   endtask

   task automatic branchJumpTest();
      startTest("branchJumpTest");
      emit(iType(opAddi, 5'd0, 5'd1, 16'd5));
      emit(iType(opAddi, 5'd0, 5'd2, 16'd5));
      emit(iType(opAddi, 5'd0, 5'd3, 16'd7));
      emit(iType(opBeq, 5'd1, 5'd2, 16'd1));   // Taken
      emit(iType(opSw, 5'd0, 5'd3, 16'h03f0)); // Skipped marker
      emit(iType(opSw, 5'd0, 5'd1, 16'h0380));
      emit(iType(opBeq, 5'd1, 5'd3, 16'd1));   // Not taken
      emit(iType(opSw, 5'd0, 5'd3, 16'h0384));
      emit(iType(opBne, 5'd1, 5'd3, 16'd1));   // Taken
      emit(iType(opSw, 5'd0, 5'd3, 16'h03f0));
      emit(iType(opSw, 5'd0, 5'd2, 16'h0388));
      emit(iType(opBne, 5'd1, 5'd2, 16'd1));   // Not taken
      emit(iType(opSw, 5'd0, 5'd3, 16'h038c));
      emit(jType(26'd15));
      emit(iType(opSw, 5'd0, 5'd3, 16'h03f0));
      emit(iType(opSw, 5'd0, 5'd1, 16'h0390));
      runProgram();
      expectStore(32'h380, 32'd5);
      expectStore(32'h384, 32'd7);
      expectStore(32'h388, 32'd5);
      expectStore(32'h38c, 32'd7);
      expectStore(32'h390, 32'd5);
   endtask

   task automatic luiZeroTest();
      immT upper;
      upper = immT'($random(seed));
      startTest("luiZeroTest");
      emit(iType(opLui, 5'd0, 5'd1, upper));
      emit(iType(opSw, 5'd0, 5'd1, 16'h0380));
      emit(iType(opAddi, 5'd0, 5'd0, 16'h1234)); // Write to r0 is dropped
      emit(iType(opSw, 5'd0, 5'd0, 16'h0384));
      emit(rType(fnOr, 5'd1, 5'd1, 5'd0));
      emit(iType(opSw, 5'd0, 5'd0, 16'h0388));
      runProgram();
      expectStore(32'h380, {upper, 16'h0000});
      expectStore(32'h384, 32'd0);
      expectStore(32'h388, 32'd0);
   endtask

   task automatic unknownOpTest();
      wordT a;
      a = $random(seed);
      startTest("unknownOpTest");
      mem[8'd192] <= a;
      emit(iType(opLw, 5'd0, 5'd1, 16'h0300));
      emit(iType(6'b010000, 5'd0, 5'd1, 16'hffff)); // Undefined opcode
      emit(rType(6'b001000, 5'd0, 5'd0, 5'd1));     // Undefined funct
      emit(iType(opSw, 5'd0, 5'd1, 16'h0380));
      runProgram();
      expectStore(32'h380, a);
   endtask

   initial
   begin
      seed        = 32'hccb0_a746;
      reset       <= 1'b1;
      memReadData <= '0;
      aluRegTest();
      aluImmTest();
      loadStoreTest();
      branchJumpTest();
      luiZeroTest();
      unknownOpTest();
      $display("Done: no errors");
      $finish;
   end

endmodule

/* tests/mipsMultiCycle_chk.sv */
`timescale 1ns/1ps

module mipsMultiCycle_chk
   import mipsIsaPkg::*;
(
   input logic clk,
   input logic reset,
   input wordT memAddr,
   input logic memRead,
   input logic memWrite
);

   // ==============================
   // Memory port rules
   noReadWithWrite: assert property (@(posedge clk) disable iff (reset)
      !(memRead && memWrite))
      else $error("memRead and memWrite high together");

   singleCycleWrite: assert property (@(posedge clk) disable iff (reset)
      memWrite |=> !memWrite)
      else $error("memWrite held for two cycles");

   alignedRead: assert property (@(posedge clk) disable iff (reset)
      memRead |-> (memAddr[1:0] == 2'b00))
      else $error("unaligned read address %h", memAddr);

   quietAfterReset: assert property (@(posedge clk)
      reset |=> (!memRead && !memWrite))
      else $error("memory strobe active right after reset");

endmodule

bind mipsMultiCycle mipsMultiCycle_chk mipsMultiCycle_chk_inst (.*);
